// File: Makefile
SOURCES := $(wildcard design/*.sv) tb/decodeTb.sv

all: run

obj_dir/VdecodeTb: build.f $(SOURCES)
	verilator --binary --timing -f build.f --top-module decodeTb -o VdecodeTb

run: obj_dir/VdecodeTb
	./obj_dir/VdecodeTb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module decodeTb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: build.f
design/isaPkg.sv
design/ctrlIf.sv
design/ctrlDecoder.sv
design/regFileBypass.sv
design/decodeStage.sv
design/idLatch.sv
design/decodeTop.sv
tb/decodeTb.sv

// File: design/ctrlDecoder.sv
// Opcode and function decoder
`timescale 1ns/10ps
module ctrlDecoder import isaPkg::*; (
   input instrWord_u instr,
   ctrlIf.decoder ctrl
);
   logic [4:0] opcode;
   logic [1:0] func;

   assign opcode = instr.rFmt.opcode;
   assign func = instr.rFmt.func;

   always_comb begin
      ctrl.regWrite = 1'b0;            // Defaults give a nop
      ctrl.memRead = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.zeroExt = 1'b0;
      ctrl.regDst = dstRt;
      ctrl.memToReg = wbAlu;
      ctrl.aluSrc1 = srcReg;
      ctrl.aluSrc2 = srcReg;
      ctrl.aluOp = aluAdd;
      ctrl.invA = 1'b0;
      ctrl.invB = 1'b0;
      ctrl.cin = 1'b0;
      ctrl.beq = 1'b0;
      ctrl.bne = 1'b0;
      ctrl.blt = 1'b0;
      ctrl.bgt = 1'b0;
      ctrl.aluJump = 1'b0;
      ctrl.halt = 1'b0;
      ctrl.err = 1'b0;
      case (opcode)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrite = 1'b1;      // rd in bits 7 to 5
            ctrl.aluSrc2 = srcImm5;
            case (opcode)
               opSubi: begin
                  ctrl.invA = 1'b1;    // imm minus rs
                  ctrl.cin = 1'b1;
               end
               opXori: begin
                  ctrl.aluOp = aluXor;
                  ctrl.zeroExt = 1'b1;
               end
               opAndni: begin
                  ctrl.aluOp = aluAndn;
                  ctrl.zeroExt = 1'b1;
               end
               opRoli: ctrl.aluOp = aluRol;
               opSlli: ctrl.aluOp = aluSll;
               opRori: ctrl.aluOp = aluRor;
               opSrli: ctrl.aluOp = aluSrl;
               default: ctrl.aluOp = aluAdd;
            endcase
         end
         opSt: begin
            ctrl.memWrite = 1'b1;      // Address rs plus imm5
            ctrl.aluSrc2 = srcImm5;
         end
         opLd: begin
            ctrl.memRead = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = wbMem;
            ctrl.aluSrc2 = srcImm5;
         end
         opStu: begin
            ctrl.memWrite = 1'b1;
            ctrl.regWrite = 1'b1;      // Updated address back to rs
            ctrl.regDst = dstRs;
            ctrl.aluSrc2 = srcImm5;
         end
         opLbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = dstRs;
            ctrl.aluSrc2 = srcImm8;
            ctrl.aluOp = aluPass;
         end
         opSlbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = dstRs;
            ctrl.zeroExt = 1'b1;
            ctrl.aluSrc2 = srcImm8;
            ctrl.aluOp = aluSlbi;      // rs shl 8 or imm8
         end
         opBtr: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = dstRd;
            ctrl.aluOp = aluBtr;
         end
         opAlu, opShift: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = dstRd;
            if (opcode == opAlu) begin
               case (func)
                  2'b00: ctrl.aluOp = aluAdd;
                  2'b01: begin
                     ctrl.aluOp = aluAdd; // rt minus rs
                     ctrl.invA = 1'b1;
                     ctrl.cin = 1'b1;
                  end
                  2'b10: ctrl.aluOp = aluXor;
                  default: ctrl.aluOp = aluAndn;
               endcase
            end else begin
               case (func)
                  2'b00: ctrl.aluOp = aluRol;
                  2'b01: ctrl.aluOp = aluSll;
                  2'b10: ctrl.aluOp = aluRor;
                  default: ctrl.aluOp = aluSrl;
               endcase
            end
         end
         opSeq, opSlt, opSle, opSco: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = dstRd;
            ctrl.memToReg = wbCond;    // Result from flags
            ctrl.invB = (opcode != opSco); // Compare by rs minus rt
            ctrl.cin = (opcode != opSco);
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.aluSrc2 = srcImm8;    // Branch displacement
            ctrl.aluOp = aluPass;
            ctrl.beq = (opcode == opBeqz);
            ctrl.bne = (opcode == opBnez);
            ctrl.blt = (opcode == opBltz);
            ctrl.bgt = (opcode == opBgez);
         end
         opJ, opJal: begin
            ctrl.aluSrc1 = srcPc;      // pc plus imm11
            ctrl.aluSrc2 = srcPc;
            ctrl.regWrite = (opcode == opJal);
            ctrl.regDst = dstLink;
            ctrl.memToReg = wbPc;
         end
         opJr, opJalr: begin
            ctrl.aluSrc2 = srcImm8;    // rs plus imm8
            ctrl.aluJump = 1'b1;
            ctrl.regWrite = (opcode == opJalr);
            ctrl.regDst = dstLink;
            ctrl.memToReg = wbPc;
         end
         default: ctrl.err = 1'b1;     // siic, rti and unused
      endcase
   end
endmodule

// File: design/ctrlIf.sv
// Decoded control bundle
`timescale 1ns/10ps
interface ctrlIf;
   logic regWrite;                   // Register file write
   logic memRead;
   logic memWrite;
   logic zeroExt;                    // Zero extend imm5 and imm8
   logic [1:0] regDst;               // Destination field select
   logic [1:0] memToReg;             // Write-back source
   logic [1:0] aluSrc1;
   logic [1:0] aluSrc2;
   logic [3:0] aluOp;
   logic invA;
   logic invB;
   logic cin;
   logic beq;
   logic bne;
   logic blt;
   logic bgt;                        // Also bgez, equality added in execute
   logic aluJump;                    // Target from register
   logic halt;
   logic err;                        // Illegal opcode

   modport decoder (
      output regWrite, memRead, memWrite, zeroExt, regDst, memToReg,
      output aluSrc1, aluSrc2, aluOp, invA, invB, cin,
      output beq, bne, blt, bgt, aluJump, halt, err
   );

   modport consumer (
      input regWrite, memRead, memWrite, zeroExt, regDst, memToReg,
      input aluSrc1, aluSrc2, aluOp, invA, invB, cin,
      input beq, bne, blt, bgt, aluJump, halt, err
   );
endinterface

// File: design/decodeStage.sv
// Instruction decode stage
`timescale 1ns/10ps
module decodeStage import isaPkg::*; (
   input logic clk,
   input logic rstN,
   input logic [dataW-1:0] instr,
   input logic wbEn,
   input logic [selW-1:0] wbReg,
   input logic [dataW-1:0] wbData,
   ctrlIf.decoder ctrl,                // Driven by the decoder inside
   output logic [dataW-1:0] readData1,
   output logic [dataW-1:0] readData2,
   output logic [dataW-1:0] imm5Ext,
   output logic [dataW-1:0] imm8Ext,
   output logic [dataW-1:0] imm11Ext,
   output logic [selW-1:0] writeReg
);
   instrWord_u iw;
   logic [7:0] imm8;
   logic [10:0] imm11;

   assign iw = instr;
   assign imm8 = instr[7:0];
   assign imm11 = instr[10:0];

   ctrlDecoder i_ctrlDecoder (
      .instr (iw),
      .ctrl  (ctrl)
   );

   regFileBypass i_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdSel1  (iw.rFmt.rs),         // Bits 10 to 8
      .rdSel2  (iw.rFmt.rt),         // Bits 7 to 5
      .rdData1 (readData1),
      .rdData2 (readData2),
      .wbEn    (wbEn),
      .wbReg   (wbReg),
      .wbData  (wbData)
   );

   // Zero or sign by opcode
   assign imm5Ext = ctrl.zeroExt ? {{(dataW-5){1'b0}}, iw.iFmt.imm}
                                 : {{(dataW-5){iw.iFmt.imm[4]}}, iw.iFmt.imm};
   assign imm8Ext = ctrl.zeroExt ? {{(dataW-8){1'b0}}, imm8}
                                 : {{(dataW-8){imm8[7]}}, imm8};
   assign imm11Ext = {{(dataW-11){imm11[10]}}, imm11}; // Jump offset, always signed

   always_comb begin
      case (ctrl.regDst)
         dstRt: writeReg = iw.iFmt.rd;   // Immediate ops and loads
         dstRs: writeReg = iw.iFmt.rs;   // lbi, slbi, stu
         dstRd: writeReg = iw.rFmt.rd;   // R-format
         default: writeReg = regLink;
      endcase
   end
endmodule

// File: design/decodeTop.sv
// Decode stage top level
`timescale 1ns/10ps
module decodeTop import isaPkg::*; (
   input logic clk,
   input logic rstN,
   input logic instrReq,
   input logic [dataW-1:0] instr,
   output logic instrAck,
   input logic wbEn,
   input logic [selW-1:0] wbReg,
   input logic [dataW-1:0] wbData,
   output logic exRegWrite,
   output logic exMemRead,
   output logic exMemWrite,
   output logic [1:0] exMemToReg,
   output logic [1:0] exAluSrc1,
   output logic [1:0] exAluSrc2,
   output logic [3:0] exAluOp,
   output logic exInvA,
   output logic exInvB,
   output logic exCin,
   output logic exBeq,
   output logic exBne,
   output logic exBlt,
   output logic exBgt,
   output logic exAluJump,
   output logic exHalt,
   output logic exErr,
   output logic [dataW-1:0] exReadData1,
   output logic [dataW-1:0] exReadData2,
   output logic [dataW-1:0] exImm5,
   output logic [dataW-1:0] exImm8,
   output logic [dataW-1:0] exImm11,
   output logic [selW-1:0] exWriteReg
);
   logic [dataW-1:0] readData1;        // Decode to stage register
   logic [dataW-1:0] readData2;
   logic [dataW-1:0] imm5Ext;
   logic [dataW-1:0] imm8Ext;
   logic [dataW-1:0] imm11Ext;
   logic [selW-1:0] writeReg;

   ctrlIf ctrlBus ();

   decodeStage i_decodeStage (
      .clk (clk), .rstN (rstN), .instr (instr),
      .wbEn (wbEn), .wbReg (wbReg), .wbData (wbData), .ctrl (ctrlBus),
      .readData1 (readData1), .readData2 (readData2), .imm5Ext (imm5Ext),
      .imm8Ext (imm8Ext), .imm11Ext (imm11Ext), .writeReg (writeReg)
   );

   idLatch i_idLatch (
      .clk (clk), .rstN (rstN), .instrReq (instrReq), .instrAck (instrAck),
      .ctrl (ctrlBus), .readData1 (readData1), .readData2 (readData2),
      .imm5Ext (imm5Ext), .imm8Ext (imm8Ext), .imm11Ext (imm11Ext), .writeReg (writeReg),
      .exRegWrite (exRegWrite), .exMemRead (exMemRead), .exMemWrite (exMemWrite),
      .exMemToReg (exMemToReg), .exAluSrc1 (exAluSrc1), .exAluSrc2 (exAluSrc2),
      .exAluOp (exAluOp), .exInvA (exInvA), .exInvB (exInvB), .exCin (exCin),
      .exBeq (exBeq), .exBne (exBne), .exBlt (exBlt), .exBgt (exBgt),
      .exAluJump (exAluJump), .exHalt (exHalt), .exErr (exErr),
      .exReadData1 (exReadData1), .exReadData2 (exReadData2),
      .exImm5 (exImm5), .exImm8 (exImm8), .exImm11 (exImm11), .exWriteReg (exWriteReg)
   );
endmodule

// File: design/idLatch.sv
// ID/EX stage register and handshake
`timescale 1ns/10ps
module idLatch import isaPkg::*; (
   input logic clk,
   input logic rstN,
   input logic instrReq,
   output logic instrAck,
   ctrlIf.consumer ctrl,
   input logic [dataW-1:0] readData1,
   input logic [dataW-1:0] readData2,
   input logic [dataW-1:0] imm5Ext,
   input logic [dataW-1:0] imm8Ext,
   input logic [dataW-1:0] imm11Ext,
   input logic [selW-1:0] writeReg,
   output logic exRegWrite,
   output logic exMemRead,
   output logic exMemWrite,
   output logic [1:0] exMemToReg,
   output logic [1:0] exAluSrc1,
   output logic [1:0] exAluSrc2,
   output logic [3:0] exAluOp,
   output logic exInvA,
   output logic exInvB,
   output logic exCin,
   output logic exBeq,
   output logic exBne,
   output logic exBlt,
   output logic exBgt,
   output logic exAluJump,
   output logic exHalt,
   output logic exErr,
   output logic [dataW-1:0] exReadData1,
   output logic [dataW-1:0] exReadData2,
   output logic [dataW-1:0] exImm5,
   output logic [dataW-1:0] exImm8,
   output logic [dataW-1:0] exImm11,
   output logic [selW-1:0] exWriteReg
);
   logic state;
   logic capture;

   assign capture = (state == stIdle) && instrReq; // Ack low, request seen
   assign instrAck = (state == stHeld);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= stIdle;
         {exRegWrite, exMemRead, exMemWrite, exMemToReg, exAluSrc1, exAluSrc2} <= '0;
         {exAluOp, exInvA, exInvB, exCin, exBeq, exBne, exBlt, exBgt} <= '0;
         {exAluJump, exHalt, exErr} <= '0;
      end else if (capture) begin
         state <= stHeld;
         exRegWrite <= ctrl.regWrite;
         exMemRead <= ctrl.memRead;
         exMemWrite <= ctrl.memWrite;
         exMemToReg <= ctrl.memToReg;
         exAluSrc1 <= ctrl.aluSrc1;
         exAluSrc2 <= ctrl.aluSrc2;
         exAluOp <= ctrl.aluOp;
         {exInvA, exInvB, exCin} <= {ctrl.invA, ctrl.invB, ctrl.cin};
         {exBeq, exBne, exBlt, exBgt} <= {ctrl.beq, ctrl.bne, ctrl.blt, ctrl.bgt};
         {exAluJump, exHalt, exErr} <= {ctrl.aluJump, ctrl.halt, ctrl.err};
      end else if ((state == stHeld) && !instrReq) begin
         state <= stIdle;              // Request removed, drop ack
      end
   end

   // Payload, held until next capture
   always_ff @(posedge clk) begin
      if (capture) begin
         exReadData1 <= readData1;
         exReadData2 <= readData2;
         exImm5 <= imm5Ext;
         exImm8 <= imm8Ext;
         exImm11 <= imm11Ext;
         exWriteReg <= writeReg;
      end
   end
endmodule

// File: design/isaPkg.sv
// ISA encodings and instruction word
package isaPkg;
   localparam int dataW = 16;                  // Datapath width
   localparam int selW = 3;                    // Register select width
   localparam int numRegs = 8;                 // Register file depth

   // Opcodes, instruction bits 15 to 11
   localparam logic [4:0] opHalt  = 5'b00000;
   localparam logic [4:0] opNop   = 5'b00001;
   localparam logic [4:0] opAddi  = 5'b01000;
   localparam logic [4:0] opSubi  = 5'b01001;
   localparam logic [4:0] opXori  = 5'b01010;
   localparam logic [4:0] opAndni = 5'b01011;
   localparam logic [4:0] opRoli  = 5'b10100;
   localparam logic [4:0] opSlli  = 5'b10101;
   localparam logic [4:0] opRori  = 5'b10110;
   localparam logic [4:0] opSrli  = 5'b10111;
   localparam logic [4:0] opSt    = 5'b10000;
   localparam logic [4:0] opLd    = 5'b10001;
   localparam logic [4:0] opStu   = 5'b10011;
   localparam logic [4:0] opSlbi  = 5'b10010;
   localparam logic [4:0] opLbi   = 5'b11000;
   localparam logic [4:0] opBtr   = 5'b11001;
   localparam logic [4:0] opAlu   = 5'b11011;  // add sub xor andn by func
   localparam logic [4:0] opShift = 5'b11010;  // rol sll ror srl by func
   localparam logic [4:0] opSeq   = 5'b11100;
   localparam logic [4:0] opSlt   = 5'b11101;
   localparam logic [4:0] opSle   = 5'b11110;
   localparam logic [4:0] opSco   = 5'b11111;
   localparam logic [4:0] opBeqz  = 5'b01100;
   localparam logic [4:0] opBnez  = 5'b01101;
   localparam logic [4:0] opBltz  = 5'b01110;
   localparam logic [4:0] opBgez  = 5'b01111;
   localparam logic [4:0] opJ     = 5'b00100;
   localparam logic [4:0] opJr    = 5'b00101;
   localparam logic [4:0] opJal   = 5'b00110;
   localparam logic [4:0] opJalr  = 5'b00111;

   // ALU operations
   localparam logic [3:0] aluAdd  = 4'd0;
   localparam logic [3:0] aluXor  = 4'd1;
   localparam logic [3:0] aluAndn = 4'd2;
   localparam logic [3:0] aluRol  = 4'd3;
   localparam logic [3:0] aluSll  = 4'd4;
   localparam logic [3:0] aluRor  = 4'd5;
   localparam logic [3:0] aluSrl  = 4'd6;
   localparam logic [3:0] aluPass = 4'd7;      // Operand B straight through
   localparam logic [3:0] aluBtr  = 4'd8;
   localparam logic [3:0] aluSlbi = 4'd9;

   // ALU operand sources; srcPc on operand B means the imm11 displacement
   localparam logic [1:0] srcReg  = 2'd0;
   localparam logic [1:0] srcImm5 = 2'd1;
   localparam logic [1:0] srcImm8 = 2'd2;
   localparam logic [1:0] srcPc   = 2'd3;

   // Write-back sources
   localparam logic [1:0] wbAlu  = 2'd0;
   localparam logic [1:0] wbMem  = 2'd1;
   localparam logic [1:0] wbPc   = 2'd2;       // Link address
   localparam logic [1:0] wbCond = 2'd3;       // Set result from flags

   // Destination selects
   localparam logic [1:0] dstRt   = 2'd0;      // Bits 7 to 5
   localparam logic [1:0] dstRs   = 2'd1;      // Bits 10 to 8
   localparam logic [1:0] dstRd   = 2'd2;      // Bits 4 to 2
   localparam logic [1:0] dstLink = 2'd3;
   localparam logic [selW-1:0] regLink = 3'd7;

   // Acknowledge controller states
   localparam logic stIdle = 1'b0;
   localparam logic stHeld = 1'b1;

   typedef union packed {
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         logic [1:0] func;
      } rFmt;                                  // Register format
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rd;
         logic [4:0] imm;
      } iFmt;                                  // Immediate format
   } instrWord_u;
endpackage

// File: design/regFileBypass.sv
// Register file with write bypass
`timescale 1ns/10ps
module regFileBypass import isaPkg::*; (
   input logic clk,
   input logic rstN,
   input logic [selW-1:0] rdSel1,
   input logic [selW-1:0] rdSel2,
   output logic [dataW-1:0] rdData1,
   output logic [dataW-1:0] rdData2,
   input logic wbEn,
   input logic [selW-1:0] wbReg,
   input logic [dataW-1:0] wbData
);
   logic [dataW-1:0] regs [numRegs];   // Architectural registers
   logic hit1;
   logic hit2;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;             // All registers read zero
         end
      end else if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   // Same-cycle write seen on the read ports
   assign hit1 = wbEn && (wbReg == rdSel1);
   assign hit2 = wbEn && (wbReg == rdSel2);

   assign rdData1 = hit1 ? wbData : regs[rdSel1];
   assign rdData2 = hit2 ? wbData : regs[rdSel2];
endmodule

// File: tb/decodeCases.txt
# name instr wbEn wbReg wbData ctrl rd1 rd2 imm5 imm8 imm11 writeReg, all hex
# ctrl: regWrite memRead memWrite memToReg[2] aluSrc1[2] aluSrc2[2] aluOp[4] invA invB cin beq bne blt bgt aluJump halt err
rst_addi_r0r1 4025 0 0 0000 404000 0000 0000 0005 0025 0025 1
rst_subi_r2r3 4A70 0 0 0000 404280 0000 0000 FFF0 0070 0270 3
rst_xori_r4r5 54BF 0 0 0000 404400 0000 0000 001F 00BF FCBF 5
rst_andni_r6r7 5EF1 0 0 0000 404800 0000 0000 0011 00F1 FEF1 7
wb_r3_roli A143 1 3 1234 404C00 0000 0000 0003 0043 0143 2
rd_r3_slli AB0F 0 0 0000 405000 1234 0000 000F 000F 030F 0
wb_disabled 43C0 0 3 DEAD 404000 1234 0000 0000 FFC0 03C0 6
bypass_rs_rori B5D5 1 5 BEEF 405400 BEEF 0000 FFF5 FFD5 FDD5 6
bypass_rt_srli B888 1 4 0F0F 405800 0000 0F0F 0008 FF88 0088 4
st 8382 0 0 0000 104000 1234 0F0F 0002 FF82 0382 4
ld 8D5E 0 0 0000 644000 BEEF 0000 FFFE 005E FD5E 2
stu 9C64 0 0 0000 504000 0F0F 1234 0004 0064 FC64 4
lbi C19C 0 0 0000 409C00 0000 0F0F FFFC FF9C 019C 1
slbi 93A7 0 0 0000 40A400 1234 BEEF 0007 00A7 03A7 3
alu_add DB94 0 0 0000 400000 1234 0F0F FFF4 FF94 0394 5
alu_sub DD65 0 0 0000 400280 BEEF 1234 0005 0065 FD65 1
alu_xor D8BE 0 0 0000 400400 0000 BEEF FFFE FFBE 00BE 7
alu_andn DC83 0 0 0000 400800 0F0F 0F0F 0003 FF83 FC83 0
shift_rol D14C 0 0 0000 400C00 0000 0000 000C 004C 014C 3
shift_sll D3A9 0 0 0000 401000 1234 BEEF 0009 FFA9 03A9 2
shift_ror D59A 0 0 0000 401400 BEEF 0F0F FFFA FF9A FD9A 6
shift_srl D407 0 0 0000 401800 0F0F 0000 0007 0007 FC07 1
seq E370 0 0 0000 4C0180 1234 1234 FFF0 0070 0370 4
slt ED88 0 0 0000 4C0180 BEEF 0F0F 0008 FF88 FD88 2
sle F078 0 0 0000 4C0180 0000 1234 FFF8 0078 0078 6
sco FCAC 0 0 0000 4C0000 0F0F BEEF 000C FFAC FCAC 3
beqz 6310 0 0 0000 009C40 1234 0000 FFF0 0010 0310 0
bnez 6DF0 0 0 0000 009C20 BEEF 0000 FFF0 FFF0 FDF0 7
bltz 7422 0 0 0000 009C10 0F0F 0000 0002 0022 FC22 1
bgez 7881 0 0 0000 009C08 0000 0F0F 0001 FF81 0081 4
j 27FE 0 0 0000 0BC000 0000 0000 FFFE FFFE FFFE 7
jal 3123 0 0 0000 4BC000 0000 0000 0003 0023 0123 7
jr 2B04 0 0 0000 088004 1234 0000 0004 0004 0304 7
jalr 3DFC 0 0 0000 488004 BEEF 0000 FFFC FFFC FDFC 7
halt 0260 0 0 0000 000002 0000 1234 0000 0060 0260 3
nop 0800 0 0 0000 000000 0000 0000 0000 0000 0000 0
illegal_op02 14BF 0 0 0000 000001 0F0F BEEF FFFF FFBF FCBF 5
illegal_op03 1B41 0 0 0000 000001 1234 0000 0001 0041 0341 2

// File: tb/decodeTb.sv
// Decode stage testbench
`timescale 1ns/10ps
module decodeTb;
   logic clk = 1'b0;
   logic rstN;
   logic instrReq;
   logic [15:0] instr;
   logic instrAck;
   logic wbEn;
   logic [2:0] wbReg;
   logic [15:0] wbData;
   logic exRegWrite, exMemRead, exMemWrite;
   logic [1:0] exMemToReg, exAluSrc1, exAluSrc2;
   logic [3:0] exAluOp;
   logic exInvA, exInvB, exCin, exBeq, exBne, exBlt, exBgt;
   logic exAluJump, exHalt, exErr;
   logic [15:0] exReadData1, exReadData2, exImm5, exImm8, exImm11;
   logic [2:0] exWriteReg;
   logic [22:0] actCtrl;                     // Held control, file column order

   string names[$];                          // One entry per case line
   logic [15:0] cInstr[$];
   logic cWbEn[$];
   logic [2:0] cWbReg[$];
   logic [15:0] cWbData[$];
   logic [22:0] cCtrl[$];
   logic [15:0] cRd1[$], cRd2[$], cImm5[$], cImm8[$], cImm11[$];
   logic [2:0] cWreg[$];
   int numCases = 0;
   int passCount = 0;
   int failCount = 0;
   int cycles = 0;
   int cycleLimit = 0;                       // Zero until the cases are known

   decodeTop i_dut (.*);

   assign actCtrl = {exRegWrite, exMemRead, exMemWrite, exMemToReg, exAluSrc1, exAluSrc2,
                     exAluOp, exInvA, exInvB, exCin, exBeq, exBne, exBlt, exBgt,
                     exAluJump, exHalt, exErr};

   always #50 clk = ~clk;                    // 100 ns period

   always @(posedge clk) begin
      cycles++;
      if (cycleLimit > 0 && cycles >= cycleLimit) begin
         $display("Timeout: the run exceeded %0d cycles", cycleLimit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic loadCases();
      int fd;
      int n;
      string line;
      string nm;
      logic [15:0] ins, wd, r1, r2, i5, i8, i11;
      logic we;
      logic [2:0] wr, wq;
      logic [22:0] ct;
      fd = $fopen("tb/decodeCases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the case file tb/decodeCases.txt");
         failCount++;
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n == 0) break;
         if (line.len() < 2 || line[0] == "#") continue; // Blank or column notes
         n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                     nm, ins, we, wr, wd, ct, r1, r2, i5, i8, i11, wq);
         if (n != 12) begin
            $display("Malformed case line: %s", line);
            failCount++;
            continue;
         end
         names.push_back(nm);
         cInstr.push_back(ins);
         cWbEn.push_back(we);
         cWbReg.push_back(wr);
         cWbData.push_back(wd);
         cCtrl.push_back(ct);
         cRd1.push_back(r1);
         cRd2.push_back(r2);
         cImm5.push_back(i5);
         cImm8.push_back(i8);
         cImm11.push_back(i11);
         cWreg.push_back(wq);
      end
      $fclose(fd);
      numCases = names.size();
   endtask

   function automatic int checkOutputs(input int idx, input string phase);
      int n;
      n = 0;
      if (actCtrl !== cCtrl[idx]) begin
         $display("[ERROR] %s%s ctrl expected %h actual %h", names[idx], phase,
                  cCtrl[idx], actCtrl);
         n++;
      end
      if (exReadData1 !== cRd1[idx]) begin
         $display("[ERROR] %s%s readData1 expected %h actual %h", names[idx], phase,
                  cRd1[idx], exReadData1);
         n++;
      end
      if (exReadData2 !== cRd2[idx]) begin
         $display("[ERROR] %s%s readData2 expected %h actual %h", names[idx], phase,
                  cRd2[idx], exReadData2);
         n++;
      end
      if (exImm5 !== cImm5[idx]) begin
         $display("[ERROR] %s%s imm5 expected %h actual %h", names[idx], phase,
                  cImm5[idx], exImm5);
         n++;
      end
      if (exImm8 !== cImm8[idx]) begin
         $display("[ERROR] %s%s imm8 expected %h actual %h", names[idx], phase,
                  cImm8[idx], exImm8);
         n++;
      end
      if (exImm11 !== cImm11[idx]) begin
         $display("[ERROR] %s%s imm11 expected %h actual %h", names[idx], phase,
                  cImm11[idx], exImm11);
         n++;
      end
      if (exWriteReg !== cWreg[idx]) begin
         $display("[ERROR] %s%s writeReg expected %h actual %h", names[idx], phase,
                  cWreg[idx], exWriteReg);
         n++;
      end
      return n;
   endfunction

   task automatic runCase(input int idx);
      int edges;
      int bad;
      bad = 0;
      instr = cInstr[idx];                   // Request and write-back together
      wbEn = cWbEn[idx];
      wbReg = cWbReg[idx];
      wbData = cWbData[idx];
      instrReq = 1'b1;
      edges = 0;
      do begin
         @(posedge clk);
         #1;
         edges++;
      end while (!instrAck && edges < 4);
      wbEn = 1'b0;
      if (!instrAck) begin
         $display("%s: the acknowledge never arrived", names[idx]);
         bad++;
      end else begin
         if (edges != 1) begin
            $display("%s: the acknowledge took %0d edges instead of one", names[idx], edges);
            bad++;
         end
         bad += checkOutputs(idx, "");
         instr = ~cInstr[idx];               // Disturb while held
         wbEn = 1'b1;
         wbReg = cInstr[idx][10:8];          // Overwrite the rs register
         wbData = ~cRd1[idx];
         @(posedge clk);
         #1;
         bad += checkOutputs(idx, " held");
         if (!instrAck) begin
            $display("%s: the acknowledge fell while the request was high", names[idx]);
            bad++;
         end
      end
      instrReq = 1'b0;
      wbEn = 1'b1;                           // Put rs back for later cases
      wbReg = cInstr[idx][10:8];
      wbData = cRd1[idx];
      edges = 0;
      do begin
         @(posedge clk);
         #1;
         edges++;
      end while (instrAck && edges < 4);
      wbEn = 1'b0;
      if (instrAck) begin
         $display("%s: the acknowledge stayed high after the request fell", names[idx]);
         bad++;
      end else if (edges != 1) begin
         $display("%s: the acknowledge took %0d edges to fall", names[idx], edges);
         bad++;
      end
      if (bad == 0) begin
         $display("PASS %s", names[idx]);
         passCount++;
      end else begin
         $display("FAIL %s", names[idx]);
         failCount++;
      end
   endtask

   initial begin
      int resetBad;
      resetBad = 0;
      rstN = 1'b0;
      instrReq = 1'b0;
      instr = '0;
      wbEn = 1'b0;
      wbReg = '0;
      wbData = '0;
      loadCases();
      cycleLimit = 12 * numCases + 50;      // Three edges per case plus reset
      repeat (10) @(posedge clk);
      #1;
      rstN = 1'b1;
      if (instrAck !== 1'b0) begin
         $display("[ERROR] reset instrAck expected 0 actual %b", instrAck);
         resetBad++;
      end
      if (actCtrl !== '0) begin             // Held control cleared
         $display("[ERROR] reset ctrl expected %h actual %h", 23'h0, actCtrl);
         resetBad++;
      end
      if (resetBad == 0) begin
         $display("PASS reset");
         passCount++;
      end else begin
         $display("FAIL reset");
         failCount++;
      end
      for (int i = 0; i < numCases; i++) begin
         runCase(i);
      end
      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0 && numCases > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end
endmodule
